//--- logic/ce_pkg.sv
/*
 * Copy engine shared definitions
 *  - transaction opcodes and copy FSM states
 *  - register map, CTRL and STATUS bit positions
 *  - address, tag, register offset and length widths
 */
package ce_pkg;

   // ----------------------------------------
   // Field widths
   // ----------------------------------------
   localparam int ADDR_W      = 32;  // Host and local address
   localparam int TAG_W       = 4;
   localparam int CSR_OFF_W   = 4;   // Offset in 8-byte registers
   localparam int CSR_OFF_LSB = 3;
   localparam int LEN_W       = 16;  // Copy length and words written

   // Transaction opcodes
   typedef enum logic [1:0] {
      OP_MMIO_WR = 2'd0,
      OP_MMIO_RD = 2'd1,
      OP_CPLD    = 2'd2,  // Host completion in, register response out
      OP_RDREQ   = 2'd3
   } ce_op_e;

   // ----------------------------------------
   // Register map
   // ----------------------------------------
   typedef enum logic [CSR_OFF_W-1:0] {
      CSR_DFH    = 4'd0,
      CSR_SRC    = 4'd1,
      CSR_DST    = 4'd2,
      CSR_LEN    = 4'd3,
      CSR_CTRL   = 4'd4,
      CSR_STATUS = 4'd5
   } ce_csr_e;

   localparam int CTRL_GO    = 0;   // Doorbell
   localparam int CTRL_CLR   = 1;   // Clear done and error

   localparam int ST_BUSY    = 0;
   localparam int ST_DONE    = 1;
   localparam int ST_ERR     = 2;
   localparam int ST_CNT_LSB = 16;  // Words written, bits 31:16

   // Copy FSM
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      ISSUE = 2'd1,
      DRAIN = 2'd2
   } ce_copy_state_e;

endpackage

//--- logic/ce_rx_decode.sv
/*
 * Host receive side of the copy engine
 * Registers rx strobes and sorts them by opcode into
 * register writes, register reads and completion data
 */
`timescale 1ns/1ps

module ce_rx_decode #(
   parameter int DATA_W = 64
) (
   input  logic                           fim_clk,
   input  logic                           rst_n,

   input  logic                           rx_valid,
   input  ce_pkg::ce_op_e                 rx_op,
   input  logic [ce_pkg::ADDR_W-1:0]      rx_addr,
   input  logic [ce_pkg::TAG_W-1:0]       rx_tag,
   input  logic [DATA_W-1:0]              rx_data,

   output logic                           reg_wr,
   output logic                           reg_rd,
   output logic [ce_pkg::CSR_OFF_W-1:0]   reg_off,
   output logic [ce_pkg::TAG_W-1:0]       reg_tag,
   output logic [DATA_W-1:0]              reg_wdata,

   output logic                           cpl_valid,
   output logic [ce_pkg::TAG_W-1:0]       cpl_tag,
   output logic [DATA_W-1:0]              cpl_data
);

   logic is_wr;
   logic is_rd;
   logic is_cpl;

   // Opcode decode, one strobe at most
   always_comb begin
      is_wr  = 1'b0;
      is_rd  = 1'b0;
      is_cpl = 1'b0;
      if (rx_valid) begin
         case (rx_op)
            ce_pkg::OP_MMIO_WR: is_wr  = 1'b1;
            ce_pkg::OP_MMIO_RD: is_rd  = 1'b1;
            ce_pkg::OP_CPLD:    is_cpl = 1'b1;
            default:            ;  // Host never sends RDREQ
         endcase
      end
   end

   // ----------------------------------------
   // Register stage
   // ----------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_wr    <= 1'b0;
         reg_rd    <= 1'b0;
         cpl_valid <= 1'b0;
      end else begin
         reg_wr    <= is_wr;
         reg_rd    <= is_rd;
         cpl_valid <= is_cpl;
      end
   end

   always_ff @(posedge fim_clk) begin
      if (is_wr || is_rd) begin
         reg_off   <= rx_addr[ce_pkg::CSR_OFF_LSB +: ce_pkg::CSR_OFF_W];
         reg_tag   <= rx_tag;
         reg_wdata <= rx_data;
      end
      if (is_cpl) begin
         cpl_tag  <= rx_tag;   // Selects the tag table entry
         cpl_data <= rx_data;
      end
   end

endmodule

//--- logic/ce_csr.sv
/*
 * Copy engine register file
 * SRC, DST and LEN configuration, CTRL doorbell and clear,
 * STATUS flags and MMIO read completions
 */
`timescale 1ns/1ps

module ce_csr #(
   parameter int         DATA_W  = 64,
   parameter logic [11:0] FEAT_ID = 12'h1
) (
   input  logic                           fim_clk,
   input  logic                           rst_n,

   input  logic                           reg_wr,
   input  logic                           reg_rd,
   input  logic [ce_pkg::CSR_OFF_W-1:0]   reg_off,
   input  logic [ce_pkg::TAG_W-1:0]       reg_tag,
   input  logic [DATA_W-1:0]              reg_wdata,

   input  logic                           busy,
   input  logic                           done_pulse,
   input  logic                           tag_err,
   input  logic [ce_pkg::LEN_W-1:0]       words_done,

   output logic                           start,
   output logic [ce_pkg::ADDR_W-1:0]      cfg_src,
   output logic [ce_pkg::ADDR_W-1:0]      cfg_dst,
   output logic [ce_pkg::LEN_W-1:0]       cfg_len,

   output logic                           rsp_valid,
   output logic [ce_pkg::TAG_W-1:0]       rsp_tag,
   output logic [DATA_W-1:0]              rsp_data
);

   logic        ctrl_wr;
   logic        doorbell;
   logic        clear;
   logic        busy_any;
   logic        done_q;
   logic        err_q;
   logic [31:0] status_word;
   logic [DATA_W-1:0] rd_word;

   assign ctrl_wr  = reg_wr && (reg_off == ce_pkg::CSR_CTRL);
   assign doorbell = ctrl_wr && reg_wdata[ce_pkg::CTRL_GO];
   assign clear    = ctrl_wr && reg_wdata[ce_pkg::CTRL_CLR];
   assign busy_any = busy || start;  // Engine takes a cycle to report busy

   // ----------------------------------------
   // Configuration and control
   // ----------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         cfg_src <= '0;
         cfg_dst <= '0;
         cfg_len <= '0;
         start   <= 1'b0;
         done_q  <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         if (reg_wr && reg_off == ce_pkg::CSR_SRC) cfg_src <= reg_wdata[ce_pkg::ADDR_W-1:0];
         if (reg_wr && reg_off == ce_pkg::CSR_DST) cfg_dst <= reg_wdata[ce_pkg::ADDR_W-1:0];
         if (reg_wr && reg_off == ce_pkg::CSR_LEN) cfg_len <= reg_wdata[ce_pkg::LEN_W-1:0];
         start <= doorbell && !busy_any;
         // Set wins over clear
         if (clear || start)       done_q <= 1'b0;
         if (done_pulse)           done_q <= 1'b1;
         if (clear)                err_q  <= 1'b0;
         if (tag_err || (doorbell && busy_any)) begin
            err_q <= 1'b1;
         end
      end
   end

   // Read data mux
   always_comb begin
      status_word = '0;
      status_word[ce_pkg::ST_BUSY] = busy;
      status_word[ce_pkg::ST_DONE] = done_q;
      status_word[ce_pkg::ST_ERR]  = err_q;
      status_word[ce_pkg::ST_CNT_LSB +: ce_pkg::LEN_W] = words_done;
      rd_word = '0;
      case (reg_off)
         ce_pkg::CSR_DFH:    rd_word[11:0] = FEAT_ID;
         ce_pkg::CSR_SRC:    rd_word[ce_pkg::ADDR_W-1:0] = cfg_src;
         ce_pkg::CSR_DST:    rd_word[ce_pkg::ADDR_W-1:0] = cfg_dst;
         ce_pkg::CSR_LEN:    rd_word[ce_pkg::LEN_W-1:0] = cfg_len;
         ce_pkg::CSR_STATUS: rd_word[31:0] = status_word;
         default:            ;  // CTRL and holes read as zero
      endcase
   end

   // ----------------------------------------
   // MMIO read completion
   // ----------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) rsp_valid <= 1'b0;
      else        rsp_valid <= reg_rd;
   end

   always_ff @(posedge fim_clk) begin
      if (reg_rd) begin
         rsp_tag  <= reg_tag;   // Requester tag goes back unchanged
         rsp_data <= rd_word;
      end
   end

endmodule

//--- logic/ce_copy_ctrl.sv
/*
 * Copy FSM of the engine
 * Issues tagged one-word host reads, keeps a tag table of
 * word indices and writes completions to local memory
 */
`timescale 1ns/1ps

module ce_copy_ctrl #(
   parameter int DATA_W  = 64,
   parameter int MAX_OUT = 4
) (
   input  logic                           fim_clk,
   input  logic                           rst_n,

   input  logic                           start,
   input  logic [ce_pkg::ADDR_W-1:0]      cfg_src,
   input  logic [ce_pkg::ADDR_W-1:0]      cfg_dst,
   input  logic [ce_pkg::LEN_W-1:0]       cfg_len,

   input  logic                           cpl_valid,
   input  logic [ce_pkg::TAG_W-1:0]       cpl_tag,
   input  logic [DATA_W-1:0]              cpl_data,

   output logic                           busy,
   output logic                           done_pulse,
   output logic                           tag_err,
   output logic [ce_pkg::LEN_W-1:0]       words_done,

   output logic                           req_valid,
   output logic [ce_pkg::ADDR_W-1:0]      req_addr,
   output logic [ce_pkg::TAG_W-1:0]       req_tag,

   output logic                           mem_wr_valid,
   output logic [ce_pkg::ADDR_W-1:0]      mem_wr_addr,
   output logic [DATA_W-1:0]              mem_wr_data
);

   localparam int NTAG  = 1 << ce_pkg::TAG_W;
   localparam int BYTES = DATA_W / 8;
   localparam int CNT_W = $clog2(MAX_OUT + 1);

   ce_pkg::ce_copy_state_e state;

   logic [ce_pkg::ADDR_W-1:0] src_ptr;
   logic [ce_pkg::ADDR_W-1:0] dst_base;
   logic [ce_pkg::LEN_W-1:0]  len_q;
   logic [ce_pkg::LEN_W-1:0]  issue_idx;
   logic [ce_pkg::TAG_W-1:0]  next_tag;
   logic [NTAG-1:0]           tag_vld;
   logic [ce_pkg::LEN_W-1:0]  tag_idx [NTAG];
   logic [CNT_W-1:0]          out_cnt;   // Requests in flight
   logic                      can_issue;
   logic                      cpl_hit;

   // Next tag must be free, as completions return out of order
   assign can_issue = (state == ce_pkg::ISSUE) && (out_cnt < MAX_OUT) && !tag_vld[next_tag];
   assign cpl_hit   = cpl_valid && tag_vld[cpl_tag];

   assign busy      = (state != ce_pkg::IDLE);
   assign req_valid = can_issue;
   assign req_addr  = src_ptr;
   assign req_tag   = next_tag;

   // ----------------------------------------
   // FSM and tag table
   // ----------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= ce_pkg::IDLE;
         len_q        <= '0;
         issue_idx    <= '0;
         next_tag     <= '0;
         tag_vld      <= '0;
         out_cnt      <= '0;
         words_done   <= '0;
         done_pulse   <= 1'b0;
         tag_err      <= 1'b0;
         mem_wr_valid <= 1'b0;
      end else begin
         done_pulse   <= 1'b0;
         tag_err      <= cpl_valid && !tag_vld[cpl_tag];  // Stray tag is dropped
         mem_wr_valid <= cpl_hit;
         out_cnt      <= out_cnt + CNT_W'(can_issue) - CNT_W'(cpl_hit);
         if (can_issue) tag_vld[next_tag] <= 1'b1;
         if (cpl_hit) begin
            tag_vld[cpl_tag] <= 1'b0;
            words_done       <= words_done + 1'b1;
         end
         case (state)
            ce_pkg::IDLE: begin
               if (start) begin
                  len_q      <= cfg_len;
                  issue_idx  <= '0;
                  words_done <= '0;
                  if (cfg_len == '0) done_pulse <= 1'b1;  // Nothing to copy
                  else               state      <= ce_pkg::ISSUE;
               end
            end
            ce_pkg::ISSUE: begin
               if (can_issue) begin
                  issue_idx <= issue_idx + 1'b1;
                  next_tag  <= next_tag + 1'b1;       // Rotates over all tags
                  if (issue_idx == len_q - 1'b1) state <= ce_pkg::DRAIN;
               end
            end
            ce_pkg::DRAIN: begin
               if (out_cnt == '0) begin
                  state      <= ce_pkg::IDLE;
                  done_pulse <= 1'b1;
               end
            end
            default: state <= ce_pkg::IDLE;
         endcase
      end
   end

   // Address and data path
   always_ff @(posedge fim_clk) begin
      if (state == ce_pkg::IDLE && start) begin
         src_ptr  <= cfg_src;
         dst_base <= cfg_dst;
      end else if (can_issue) begin
         src_ptr  <= src_ptr + ce_pkg::ADDR_W'(BYTES);
      end
      if (can_issue) tag_idx[next_tag] <= issue_idx;
      if (cpl_hit) begin
         mem_wr_addr <= dst_base
                        + ce_pkg::ADDR_W'(tag_idx[cpl_tag]) * ce_pkg::ADDR_W'(BYTES);
         mem_wr_data <= cpl_data;
      end
   end

endmodule

//--- logic/ce_tx_arb.sv
/*
 * Host transmit side of the copy engine
 * Merges register completions and read requests onto one
 * registered tx strobe, with a four-entry in-order queue
 */
`timescale 1ns/1ps

module ce_tx_arb #(
   parameter int DATA_W = 64
) (
   input  logic                           fim_clk,
   input  logic                           rst_n,

   input  logic                           rsp_valid,
   input  logic [ce_pkg::TAG_W-1:0]       rsp_tag,
   input  logic [DATA_W-1:0]              rsp_data,
   input  logic                           req_valid,
   input  logic [ce_pkg::ADDR_W-1:0]      req_addr,
   input  logic [ce_pkg::TAG_W-1:0]       req_tag,

   output logic                           tx_valid,
   output ce_pkg::ce_op_e                 tx_op,
   output logic [ce_pkg::ADDR_W-1:0]      tx_addr,
   output logic [ce_pkg::TAG_W-1:0]       tx_tag,
   output logic [DATA_W-1:0]              tx_data
);

   typedef struct packed {
      ce_pkg::ce_op_e            op;
      logic [ce_pkg::ADDR_W-1:0] addr;
      logic [ce_pkg::TAG_W-1:0]  tag;
      logic [DATA_W-1:0]         data;
   } ent_t;

   ent_t       q_mem [4];
   logic [1:0] wr_ptr;
   logic [1:0] rd_ptr;
   logic [2:0] q_cnt;
   logic       q_empty;
   logic [1:0] n_new;
   logic [1:0] n_push;
   ent_t       rsp_ent;
   ent_t       req_ent;
   ent_t       new0;
   ent_t       out_ent;

   assign rsp_ent = '{op: ce_pkg::OP_CPLD, addr: '0, tag: rsp_tag, data: rsp_data};
   assign req_ent = '{op: ce_pkg::OP_RDREQ, addr: req_addr, tag: req_tag, data: '0};
   assign new0    = rsp_valid ? rsp_ent : req_ent;  // Completion has priority
   assign q_empty = (q_cnt == '0);
   assign n_new   = {1'b0, rsp_valid} + {1'b0, req_valid};

   // Empty queue bypasses the first new entry, otherwise head goes first
   assign out_ent = q_empty ? new0 : q_mem[rd_ptr];
   assign n_push  = q_empty ? {1'b0, rsp_valid && req_valid} : n_new;

   // ----------------------------------------
   // Queue
   // ----------------------------------------
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         q_cnt  <= '0;
      end else begin
         wr_ptr <= wr_ptr + n_push;
         rd_ptr <= rd_ptr + {1'b0, !q_empty};
         q_cnt  <= q_cnt + {1'b0, n_push} - {2'b0, !q_empty};
      end
   end

   always_ff @(posedge fim_clk) begin
      if (n_push != 2'd0) q_mem[wr_ptr] <= q_empty ? req_ent : new0;
      if (n_push == 2'd2) q_mem[wr_ptr + 2'd1] <= req_ent;
   end

   // Registered output
   always_ff @(posedge fim_clk or negedge rst_n) begin
      if (!rst_n) tx_valid <= 1'b0;
      else        tx_valid <= !q_empty || (n_new != 2'd0);
   end

   always_ff @(posedge fim_clk) begin
      tx_op   <= out_ent.op;
      tx_addr <= out_ent.addr;
      tx_tag  <= out_ent.tag;
      tx_data <= out_ent.data;
   end

endmodule

//--- logic/ce_top.sv
/*
 * Copy engine top level
 * Receive decode, register file, copy FSM and tx merge
 */
`timescale 1ns/1ps

module ce_top #(
   parameter int          DATA_W  = 64,
   parameter int          MAX_OUT = 4,     // Up to 16
   parameter logic [11:0] FEAT_ID = 12'h1
) (
   input  logic                           fim_clk,
   input  logic                           rst_n,

   input  logic                           rx_valid,
   input  ce_pkg::ce_op_e                 rx_op,
   input  logic [ce_pkg::ADDR_W-1:0]      rx_addr,
   input  logic [ce_pkg::TAG_W-1:0]       rx_tag,
   input  logic [DATA_W-1:0]              rx_data,

   output logic                           tx_valid,
   output ce_pkg::ce_op_e                 tx_op,
   output logic [ce_pkg::ADDR_W-1:0]      tx_addr,
   output logic [ce_pkg::TAG_W-1:0]       tx_tag,
   output logic [DATA_W-1:0]              tx_data,

   output logic                           mem_wr_valid,
   output logic [ce_pkg::ADDR_W-1:0]      mem_wr_addr,
   output logic [DATA_W-1:0]              mem_wr_data
);

   // ----------------------------------------
   // Internal wires
   // ----------------------------------------
   logic                          reg_wr, reg_rd;
   logic [ce_pkg::CSR_OFF_W-1:0]  reg_off;
   logic [ce_pkg::TAG_W-1:0]      reg_tag, cpl_tag, rsp_tag, req_tag;
   logic [DATA_W-1:0]             reg_wdata, cpl_data, rsp_data;
   logic                          cpl_valid, rsp_valid, req_valid;
   logic                          start, busy, done_pulse, tag_err;
   logic [ce_pkg::ADDR_W-1:0]     cfg_src, cfg_dst, req_addr;
   logic [ce_pkg::LEN_W-1:0]      cfg_len, words_done;

   ce_rx_decode #(.DATA_W(DATA_W)) i_rx_decode (
      .fim_clk, .rst_n,
      .rx_valid, .rx_op, .rx_addr, .rx_tag, .rx_data,
      .reg_wr, .reg_rd, .reg_off, .reg_tag, .reg_wdata,
      .cpl_valid, .cpl_tag, .cpl_data
   );

   ce_csr #(.DATA_W(DATA_W), .FEAT_ID(FEAT_ID)) i_csr (
      .fim_clk, .rst_n,
      .reg_wr, .reg_rd, .reg_off, .reg_tag, .reg_wdata,
      .busy, .done_pulse, .tag_err, .words_done,
      .start, .cfg_src, .cfg_dst, .cfg_len,
      .rsp_valid, .rsp_tag, .rsp_data
   );

   ce_copy_ctrl #(.DATA_W(DATA_W), .MAX_OUT(MAX_OUT)) i_copy_ctrl (
      .fim_clk, .rst_n,
      .start, .cfg_src, .cfg_dst, .cfg_len,
      .cpl_valid, .cpl_tag, .cpl_data,
      .busy, .done_pulse, .tag_err, .words_done,
      .req_valid, .req_addr, .req_tag,
      .mem_wr_valid, .mem_wr_addr, .mem_wr_data
   );

   ce_tx_arb #(.DATA_W(DATA_W)) i_tx_arb (
      .fim_clk, .rst_n,
      .rsp_valid, .rsp_tag, .rsp_data,
      .req_valid, .req_addr, .req_tag,
      .tx_valid, .tx_op, .tx_addr, .tx_tag, .tx_data
   );

endmodule

//--- verif/ce_sva.sv
/*
 * Bound checks on the copy engine top level
 * Reset state, tx opcode legality, outstanding read limit,
 * tx queue depth
 */
`timescale 1ns/1ps

module ce_sva #(
   parameter int MAX_OUT = 4
) (
   input logic                            fim_clk,
   input logic                            rst_n,
   input logic                            tx_valid,
   input ce_pkg::ce_op_e                  tx_op,
   input logic                            mem_wr_valid,
   input ce_pkg::ce_copy_state_e          state,
   input logic [$clog2(MAX_OUT+1)-1:0]    out_cnt,   // Same width as the FSM counter
   input logic [2:0]                      q_cnt
);

   int fail_cnt = 0;   // Failed assertions so far

   // ----------------------------------------
   // Reset behavior
   // ----------------------------------------
   reset_quiet: assert property (@(posedge fim_clk) !rst_n |-> (!tx_valid && !mem_wr_valid))
      else begin
         fail_cnt++;
         $error("tx or mem_wr strobe while in reset");
      end

   first_cycle_quiet: assert property (@(posedge fim_clk)
      $rose(rst_n) |-> (!tx_valid && !mem_wr_valid) ##1 (!tx_valid && !mem_wr_valid))
      else begin
         fail_cnt++;
         $error("tx or mem_wr strobe in the first cycle after reset");
      end

   // ----------------------------------------
   // Running checks
   // ----------------------------------------
   tx_op_legal: assert property (@(posedge fim_clk) disable iff (!rst_n)
      tx_valid |-> (tx_op inside {ce_pkg::OP_CPLD, ce_pkg::OP_RDREQ}))
      else begin
         fail_cnt++;
         $error("illegal opcode on tx");
      end

   out_limit: assert property (@(posedge fim_clk) disable iff (!rst_n) out_cnt <= MAX_OUT)
      else begin
         fail_cnt++;
         $error("more reads in flight than allowed");
      end

   // Nothing in flight once the FSM is back in IDLE
   idle_empty: assert property (@(posedge fim_clk) disable iff (!rst_n)
      (state == ce_pkg::IDLE) |-> (out_cnt == '0))
      else begin
         fail_cnt++;
         $error("reads still in flight in IDLE");
      end

   q_limit: assert property (@(posedge fim_clk) disable iff (!rst_n) q_cnt <= 3'd4)
      else begin
         fail_cnt++;
         $error("tx queue overflow");
      end

endmodule

bind ce_top ce_sva #(.MAX_OUT(MAX_OUT)) i_ce_sva (
   .fim_clk, .rst_n, .tx_valid, .tx_op, .mem_wr_valid,
   .state(i_copy_ctrl.state),
   .out_cnt(i_copy_ctrl.out_cnt),
   .q_cnt(i_tx_arb.q_cnt)
);

//--- verif/ce_tb.sv
/*
 * Testbench for the copy engine top level
 * Clock and reset, LFSR, host model answering reads out of
 * order, local memory capture, test sequence and checks
 */
`timescale 1ns/1ps

module ce_tb;

   localparam int          DATA_W   = 64;
   localparam int          MAX_OUT  = 4;
   localparam logic [11:0] FEAT_ID  = 12'h1;
   localparam logic [31:0] SRC_BASE = 32'h0000_1000;
   localparam logic [31:0] DST_BASE = 32'h0000_8000;
   localparam int          COPY_LEN = 12;
   localparam int          RSP_WAIT = 60;   // Cycles allowed per register read
   localparam int          POLLS    = 40;

   logic                fim_clk = 1'b0;
   logic                rst_n;
   logic                rx_valid;
   ce_pkg::ce_op_e      rx_op;
   logic [31:0]         rx_addr;
   logic [3:0]          rx_tag;
   logic [DATA_W-1:0]   rx_data;
   logic                tx_valid;
   ce_pkg::ce_op_e      tx_op;
   logic [31:0]         tx_addr;
   logic [3:0]          tx_tag;
   logic [DATA_W-1:0]   tx_data;
   logic                mem_wr_valid;
   logic [31:0]         mem_wr_addr;
   logic [DATA_W-1:0]   mem_wr_data;

   // Host and local memory models
   logic [15:0]         lfsr = 16'd46;
   logic [DATA_W-1:0]   host_mem [64];
   logic [DATA_W-1:0]   local_mem [64];
   int                  req_seen [64];
   int                  wr_seen [64];
   ce_pkg::ce_op_e      send_op_q [$];
   logic [31:0]         send_addr_q [$];
   logic [3:0]          send_tag_q [$];
   logic [DATA_W-1:0]   send_data_q [$];
   logic [31:0]         pend_addr_q [$];
   logic [3:0]          pend_tag_q [$];
   int                  pend_due_q [$];
   logic [3:0]          rsp_tag_q [$];
   logic [DATA_W-1:0]   rsp_data_q [$];
   logic [3:0]          rd_tag = 4'h3;
   int                  cyc = 0;
   int                  err_cnt = 0;
   int                  rd_sent = 0;
   int                  cpl_cnt = 0;
   int                  req_total = 0;
   int                  wr_total = 0;

   always #10 fim_clk = ~fim_clk;

   ce_top #(.DATA_W(DATA_W), .MAX_OUT(MAX_OUT), .FEAT_ID(FEAT_ID)) i_ce_top (.*);

   // ----------------------------------------
   // Random numbers and checks
   // ----------------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic flag_error(input string msg);
      err_cnt++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         err_cnt++;
         $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
      end
   endtask

   // ----------------------------------------
   // Host side traffic
   // ----------------------------------------
   task automatic host_send(input ce_pkg::ce_op_e op, input logic [31:0] addr,
                            input logic [3:0] tag, input logic [DATA_W-1:0] data);
      send_op_q.push_back(op);
      send_addr_q.push_back(addr);
      send_tag_q.push_back(tag);
      send_data_q.push_back(data);
   endtask

   task automatic write_reg(input logic [3:0] off, input logic [DATA_W-1:0] data);
      host_send(ce_pkg::OP_MMIO_WR, {25'b0, off, 3'b0}, 4'h0, data);
   endtask

   task automatic read_reg(input logic [3:0] off, output logic [DATA_W-1:0] data);
      int         n;
      logic [3:0] tag;
      tag    = rd_tag;
      rd_tag = rd_tag + 4'h1;
      data   = '0;
      n      = 0;
      host_send(ce_pkg::OP_MMIO_RD, {25'b0, off, 3'b0}, tag, '0);
      rd_sent++;
      while (rsp_tag_q.size() == 0 && n < RSP_WAIT) begin
         @(negedge fim_clk);
         n++;
      end
      if (rsp_tag_q.size() == 0) begin
         flag_error($sformatf("no completion for register read at offset %0d", off));
      end else begin
         check_val("tx_tag", rsp_tag_q.pop_front(), tag);
         data = rsp_data_q.pop_front();
      end
   endtask

   task automatic poll_status(input int bit_pos, output logic [DATA_W-1:0] st);
      int n;
      n = 0;
      read_reg(ce_pkg::CSR_STATUS, st);
      while (!st[bit_pos] && n < POLLS) begin
         read_reg(ce_pkg::CSR_STATUS, st);
         n++;
      end
      if (!st[bit_pos]) flag_error($sformatf("status bit %0d never set", bit_pos));
   endtask

   // Host model, samples tx and mem_wr, drives rx
   always @(posedge fim_clk) begin
      int idx;
      int n_ready;
      int pick;
      int k;
      cyc = cyc + 1;
      if (tx_valid && tx_op == ce_pkg::OP_RDREQ) begin
         req_total++;
         assert (tx_addr >= SRC_BASE && tx_addr < SRC_BASE + COPY_LEN * 8 && tx_addr[2:0] == 0)
            else flag_error($sformatf("read request address %h outside the source", tx_addr));
         req_seen[6'((tx_addr - SRC_BASE) >> 3)]++;
         pend_addr_q.push_back(tx_addr);
         pend_tag_q.push_back(tx_tag);
         pend_due_q.push_back(cyc + 1 + int'(rand_bits(3) % 6));   // 1 to 6 cycles
      end
      if (tx_valid && tx_op == ce_pkg::OP_CPLD) begin
         cpl_cnt++;
         rsp_tag_q.push_back(tx_tag);
         rsp_data_q.push_back(tx_data);
      end
      if (mem_wr_valid) begin
         wr_total++;
         assert (mem_wr_addr >= DST_BASE && mem_wr_addr < DST_BASE + COPY_LEN * 8
                 && mem_wr_addr[2:0] == 0)
            else flag_error($sformatf("local write address %h outside the target", mem_wr_addr));
         idx = 6'((mem_wr_addr - DST_BASE) >> 3);
         local_mem[idx] = mem_wr_data;
         wr_seen[idx]++;
      end
      rx_valid <= 1'b0;
      if (send_op_q.size() > 0) begin    // Register traffic goes first
         rx_valid <= 1'b1;
         rx_op    <= send_op_q.pop_front();
         rx_addr  <= send_addr_q.pop_front();
         rx_tag   <= send_tag_q.pop_front();
         rx_data  <= send_data_q.pop_front();
      end else begin
         n_ready = 0;
         foreach (pend_due_q[i]) if (pend_due_q[i] <= cyc) n_ready++;
         if (n_ready > 0) begin
            pick = int'(rand_bits(3)) % n_ready;   // Random ready entry
            k    = 0;
            while (pend_due_q[k] > cyc || pick > 0) begin
               if (pend_due_q[k] <= cyc) pick--;
               k++;
            end
            rx_valid <= 1'b1;
            rx_op    <= ce_pkg::OP_CPLD;
            rx_addr  <= '0;
            rx_tag   <= pend_tag_q[k];
            rx_data  <= host_mem[6'((pend_addr_q[k] - SRC_BASE) >> 3)];
            pend_addr_q.delete(k);
            pend_tag_q.delete(k);
            pend_due_q.delete(k);
         end
      end
   end

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] hi;
      logic [DATA_W-1:0] exp;
      rst_n    = 1'b0;
      rx_valid = 1'b0;
      rx_op    = ce_pkg::OP_MMIO_WR;
      rx_addr  = '0;
      rx_tag   = '0;
      rx_data  = '0;
      for (int i = 0; i < 64; i++) begin
         hi          = rand_bits(32);
         host_mem[i] = {hi[31:0], rand_bits(32)};
      end
      repeat (2) @(posedge fim_clk);
      rst_n <= 1'b1;
      repeat (2) @(negedge fim_clk);

      read_reg(ce_pkg::CSR_STATUS, rd);
      check_val("status after reset", rd, '0);
      read_reg(ce_pkg::CSR_DFH, rd);
      check_val("dfh feature id", rd[11:0], FEAT_ID);

      write_reg(ce_pkg::CSR_SRC, SRC_BASE);
      write_reg(ce_pkg::CSR_DST, DST_BASE);
      write_reg(ce_pkg::CSR_LEN, COPY_LEN);
      read_reg(ce_pkg::CSR_SRC, rd);
      check_val("src", rd, SRC_BASE);
      read_reg(ce_pkg::CSR_DST, rd);
      check_val("dst", rd, DST_BASE);
      read_reg(ce_pkg::CSR_LEN, rd);
      check_val("len", rd, COPY_LEN);
      read_reg(4'd9, rd);
      check_val("undefined offset", rd, '0);

      // Second doorbell lands while the copy starts
      write_reg(ce_pkg::CSR_CTRL, 64'h1);
      write_reg(ce_pkg::CSR_CTRL, 64'h1);
      read_reg(ce_pkg::CSR_STATUS, rd);
      check_val("status busy during copy", rd[ce_pkg::ST_BUSY], 1'b1);
      poll_status(ce_pkg::ST_DONE, rd);
      exp = (64'(COPY_LEN) << 16) | (64'd1 << ce_pkg::ST_DONE) | (64'd1 << ce_pkg::ST_ERR);
      check_val("status after copy", rd, exp);
      for (int i = 0; i < COPY_LEN; i++) begin
         check_val($sformatf("local_mem[%0d]", i), local_mem[i], host_mem[i]);
         check_val($sformatf("writes to word %0d", i), wr_seen[i], 1);
         check_val($sformatf("requests for word %0d", i), req_seen[i], 1);
      end
      check_val("read request count", req_total, COPY_LEN);

      write_reg(ce_pkg::CSR_CTRL, 64'h2);
      read_reg(ce_pkg::CSR_STATUS, rd);
      check_val("status after clear", rd, 64'(COPY_LEN) << 16);

      // Completion for a tag that is not in flight
      host_send(ce_pkg::OP_CPLD, '0, 4'd9, 64'h5a5a_0f0f_a5a5_f0f0);
      poll_status(ce_pkg::ST_ERR, rd);
      check_val("status after stray tag", rd, (64'(COPY_LEN) << 16) | (64'd1 << ce_pkg::ST_ERR));
      check_val("mem write count", wr_total, COPY_LEN);
      write_reg(ce_pkg::CSR_CTRL, 64'h2);
      read_reg(ce_pkg::CSR_STATUS, rd);
      check_val("status after second clear", rd, 64'(COPY_LEN) << 16);
      check_val("register completion count", cpl_cnt, rd_sent);

      $display("Errors: %0d check failures, %0d assertion failures",
               err_cnt, i_ce_top.i_ce_sva.fail_cnt);
      if (err_cnt == 0 && i_ce_top.i_ce_sva.fail_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- ce_subsys.f
logic/ce_pkg.sv
logic/ce_rx_decode.sv
logic/ce_csr.sv
logic/ce_copy_ctrl.sv
logic/ce_tx_arb.sv
logic/ce_top.sv
verif/ce_sva.sv
verif/ce_tb.sv
